//--- src/fifo_pkg.sv
`default_nettype none

package fifo_pkg;

	////////////////////////////////////////
	// default sizes
	////////////////////////////////////////

	// word width of the stream
	localparam int DATA_W_DEF = 32;
	// ram address width, 16 entries
	localparam int ADDR_W_DEF = 4;
	// threshold for have_n and almost_full
	localparam int ALMOST_N_DEF = 4;

	////////////////////////////////////////
	// encodings
	////////////////////////////////////////

	// ram fill quartile, full ram saturates at q3
	typedef enum logic [1:0] {
		LVL_Q0 = 2'd0,
		LVL_Q1 = 2'd1,
		LVL_Q2 = 2'd2,
		LVL_Q3 = 2'd3
	} fifo_level_e;

	// output register states
	typedef enum logic [1:0] {
		OUT_IDLE = 2'd0,
		OUT_WAIT = 2'd1,
		OUT_HOLD = 2'd2
	} out_state_e;

endpackage

`default_nettype wire

//--- src/fifo_ram_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fifo_ram_if
	import fifo_pkg::*;
#(
	parameter int DATA_W = DATA_W_DEF,
	parameter int ADDR_W = ADDR_W_DEF
) ();

	// write port
	logic              wr_en;
	logic [ADDR_W-1:0] wr_addr;
	logic [DATA_W-1:0] wr_data;

	// read port, data valid one cycle after rd_en
	logic              rd_en;
	logic [ADDR_W-1:0] rd_addr;
	logic [DATA_W-1:0] rd_data;

	// controller side
	modport ctrl (
		output wr_en, wr_addr, wr_data,
		output rd_en, rd_addr,
		input  rd_data
	);

	// storage side
	modport ram (
		input  wr_en, wr_addr, wr_data,
		input  rd_en, rd_addr,
		output rd_data
	);

endinterface

`default_nettype wire

//--- src/fifo_ram.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_ram
	import fifo_pkg::*;
#(
	parameter int DATA_W = DATA_W_DEF,
	parameter int ADDR_W = ADDR_W_DEF
) (
	input  wire logic clk,
	fifo_ram_if.ram   ram
);

	localparam int DEPTH = 1 << ADDR_W;

	// storage array, no reset
	logic [DATA_W-1:0] mem [DEPTH];

	// write port
	always_ff @(posedge clk) begin
		if (ram.wr_en) begin
			mem[ram.wr_addr] <= ram.wr_data;
		end
	end

	// registered read port
	// the controller never reads a slot in the cycle it is written
	always_ff @(posedge clk) begin
		if (ram.rd_en) begin
			ram.rd_data <= mem[ram.rd_addr];
		end
	end

endmodule

`default_nettype wire

//--- src/fifo_in_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_in_stage
	import fifo_pkg::*;
#(
	parameter int DATA_W = DATA_W_DEF
) (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire logic              clr,
	input  wire logic              enq,
	input  wire logic [DATA_W-1:0] d_in,
	input  wire logic              take,
	output logic                   push,
	output logic [DATA_W-1:0]      push_data,
	output logic                   full_n
);

	// one word holding register
	logic              held;
	logic [DATA_W-1:0] word;

	// accepts when empty or when the held word leaves this edge
	assign full_n = !held || take;

	// offer the held word to the controller
	assign push      = held;
	assign push_data = word;

	////////////////////////////////////////
	// occupancy
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst) begin
			held <= 1'b0;
		end else if (clr) begin
			held <= 1'b0;
		end else if (enq && full_n) begin
			// new word replaces or follows the drained one
			held <= 1'b1;
		end else if (take) begin
			held <= 1'b0;
		end
	end

	// payload
	always_ff @(posedge clk) begin
		if (enq && full_n) begin
			word <= d_in;
		end
	end

endmodule

`default_nettype wire

//--- src/fifo_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_ctrl
	import fifo_pkg::*;
#(
	parameter int DATA_W   = DATA_W_DEF,
	parameter int ADDR_W   = ADDR_W_DEF,
	parameter int ALMOST_N = ALMOST_N_DEF
) (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire logic              clr,
	input  wire logic              push,
	input  wire logic [DATA_W-1:0] push_data,
	input  wire logic              room,
	fifo_ram_if.ctrl               ram,
	output logic                   take,
	output logic                   rd_issued,
	output fifo_level_e            level,
	output logic                   have_n,
	output logic                   almost_full
);

	localparam int DEPTH = 1 << ADDR_W;
	// flag thresholds on the count
	localparam logic [ADDR_W:0] HAVE_TH = (ADDR_W+1)'(ALMOST_N);
	localparam logic [ADDR_W:0] FULL_TH = (ADDR_W+1)'(DEPTH - ALMOST_N);

	logic [ADDR_W-1:0] wp;
	logic [ADDR_W-1:0] rp;
	logic [ADDR_W-1:0] wp_pl1;
	logic [ADDR_W-1:0] rp_pl1;
	// guard bit, set when a write closes the gap to rp
	logic              gb;
	logic [ADDR_W:0]   cnt;
	logic [ADDR_W:0]   cnt_nxt;
	logic              full;
	logic              empty;
	logic              wr;
	logic              rd;

	////////////////////////////////////////
	// full and empty from pointers
	////////////////////////////////////////

	// equal pointers, guard tells which
	assign full  = (wp == rp) && gb;
	assign empty = (wp == rp) && !gb;

	assign take = !full;
	assign wr   = push && take;
	// read only when the output register can take the word
	assign rd   = !empty && room;

	assign wp_pl1 = wp + ADDR_W'(1);
	assign rp_pl1 = rp + ADDR_W'(1);

	// ram port drive
	assign ram.wr_en   = wr;
	assign ram.wr_addr = wp;
	assign ram.wr_data = push_data;
	assign ram.rd_en   = rd;
	assign ram.rd_addr = rp;
	assign rd_issued   = rd;

	////////////////////////////////////////
	// pointers and guard bit
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst || clr) begin
			wp <= '0;
			rp <= '0;
			gb <= 1'b0;
		end else begin
			if (wr) begin
				wp <= wp_pl1;
			end
			if (rd) begin
				rp <= rp_pl1;
			end
			// guard only moves when one side acts alone
			if (wr && !rd && (wp_pl1 == rp)) begin
				gb <= 1'b1;
			end else if (rd && !wr) begin
				gb <= 1'b0;
			end
		end
	end

	////////////////////////////////////////
	// occupancy and status
	////////////////////////////////////////

	always_comb begin
		case ({wr, rd})
			2'b10:   cnt_nxt = cnt + (ADDR_W+1)'(1);
			2'b01:   cnt_nxt = cnt - (ADDR_W+1)'(1);
			default: cnt_nxt = cnt;
		endcase
	end

	// flags follow the next count so they line up with cnt
	always_ff @(posedge clk) begin
		if (!rst || clr) begin
			cnt         <= '0;
			have_n      <= 1'b0;
			almost_full <= 1'b0;
		end else begin
			cnt         <= cnt_nxt;
			have_n      <= cnt_nxt >= HAVE_TH;
			almost_full <= cnt_nxt >= FULL_TH;
		end
	end

	// quartile from top count bits, top bit saturates
	assign level = cnt[ADDR_W] ? LVL_Q3 : fifo_level_e'(cnt[ADDR_W-1 -: 2]);

endmodule

`default_nettype wire

//--- src/fifo_out_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_out_stage
	import fifo_pkg::*;
#(
	parameter int DATA_W = DATA_W_DEF
) (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire logic              clr,
	input  wire logic              rd_issued,
	input  wire logic [DATA_W-1:0] rd_data,
	input  wire logic              deq,
	output logic                   room,
	output logic [DATA_W-1:0]      d_out,
	output logic                   empty_n
);

	out_state_e state;
	out_state_e state_nxt;

	// room when idle, or when the presented word leaves now
	assign room    = (state == OUT_IDLE) || ((state == OUT_HOLD) && deq);
	assign empty_n = (state == OUT_HOLD);

	////////////////////////////////////////
	// output FSM
	////////////////////////////////////////

	always_comb begin
		state_nxt = state;
		case (state)
			OUT_IDLE: begin
				if (rd_issued) begin
					state_nxt = OUT_WAIT;
				end
			end
			// ram data lands this edge
			OUT_WAIT: state_nxt = OUT_HOLD;
			OUT_HOLD: begin
				// back to back read keeps the stream going
				if (deq) begin
					state_nxt = rd_issued ? OUT_WAIT : OUT_IDLE;
				end
			end
			default: state_nxt = OUT_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst || clr) begin
			state <= OUT_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// capture registered ram output one edge after the read
	always_ff @(posedge clk) begin
		if (state == OUT_WAIT) begin
			d_out <= rd_data;
		end
	end

endmodule

`default_nettype wire

//--- src/srl_fifo_top.sv
`timescale 1ns/1ps
`default_nettype none

module srl_fifo_top
	import fifo_pkg::*;
#(
	parameter int DATA_W   = DATA_W_DEF,
	parameter int ADDR_W   = ADDR_W_DEF,
	parameter int ALMOST_N = ALMOST_N_DEF
) (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire logic              clr,
	input  wire logic              enq,
	input  wire logic [DATA_W-1:0] d_in,
	input  wire logic              deq,
	output logic [DATA_W-1:0]      d_out,
	output logic                   empty_n,
	output logic                   full_n,
	output logic [1:0]             level,
	output logic                   have_n,
	output logic                   almost_full
);

	// input register to controller
	logic              push;
	logic [DATA_W-1:0] push_data;
	logic              take;
	// controller to output register
	logic              room;
	logic              rd_issued;

	fifo_ram_if #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) ram_if ();

	////////////////////////////////////////
	// stages
	////////////////////////////////////////

	fifo_in_stage #(.DATA_W(DATA_W)) in_i (
		.clk       (clk),
		.rst       (rst),
		.clr       (clr),
		.enq       (enq),
		.d_in      (d_in),
		.take      (take),
		.push      (push),
		.push_data (push_data),
		.full_n    (full_n)
	);

	fifo_ctrl #(.DATA_W(DATA_W), .ADDR_W(ADDR_W), .ALMOST_N(ALMOST_N)) ctrl_i (
		.clk         (clk),
		.rst         (rst),
		.clr         (clr),
		.push        (push),
		.push_data   (push_data),
		.room        (room),
		.ram         (ram_if.ctrl),
		.take        (take),
		.rd_issued   (rd_issued),
		.level       (level),
		.have_n      (have_n),
		.almost_full (almost_full)
	);

	fifo_ram #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) ram_i (
		.clk (clk),
		.ram (ram_if.ram)
	);

	fifo_out_stage #(.DATA_W(DATA_W)) out_i (
		.clk       (clk),
		.rst       (rst),
		.clr       (clr),
		.rd_issued (rd_issued),
		.rd_data   (ram_if.rd_data),
		.deq       (deq),
		.room      (room),
		.d_out     (d_out),
		.empty_n   (empty_n)
	);

endmodule

`default_nettype wire

//--- verif/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
	parameter int PERIOD_NS  = 10,
	parameter int RST_CYCLES = 2
) (
	output logic clk,
	output logic rst
);

	// free running clock
	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// active low reset, released on a rising edge
	initial begin
		rst = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b1;
	end

endmodule

`default_nettype wire

//--- verif/srl_fifo_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module srl_fifo_assertions
	import fifo_pkg::*;
#(
	parameter int DATA_W = DATA_W_DEF
) (
	input wire logic              clk,
	input wire logic              rst,
	input wire logic              clr,
	input wire logic              deq,
	input wire logic [DATA_W-1:0] d_out,
	input wire logic              empty_n,
	input wire logic              full_n,
	input wire logic [1:0]        level,
	input wire logic              have_n,
	input wire logic              almost_full,
	input wire logic              push,
	input wire logic              take,
	input wire logic              rd_issued
);

	// failures seen so far, read by the testbench top
	int fail_cnt = 0;

	logic idle_look;
	logic wr;

	// empty fifo with every status flag low
	assign idle_look = !empty_n && full_n && (level == 2'd0) && !have_n && !almost_full;
	// word moves from input register into the ram
	assign wr = push && take;

	////////////////////////////////////////
	// status after reset and clear
	////////////////////////////////////////

	a_reset_state: assert property (@(posedge clk) $rose(rst) |-> idle_look)
		else begin
			$error("status flags not idle after reset");
			fail_cnt++;
		end

	a_clear_state: assert property (@(posedge clk) disable iff (!rst) clr |=> idle_look)
		else begin
			$error("status flags not idle after clear");
			fail_cnt++;
		end

	////////////////////////////////////////
	// stream protocol
	////////////////////////////////////////

	// presented word waits for the consumer
	a_hold_word: assert property (@(posedge clk) disable iff (!rst)
		(empty_n && !deq) |=> $stable(d_out))
		else begin
			$error("d_out changed while waiting for deq");
			fail_cnt++;
		end

	a_not_stuck: assert property (@(posedge clk) disable iff (!rst) (full_n || empty_n))
		else begin
			$error("full_n and empty_n both low");
			fail_cnt++;
		end

	// a lone write can only raise the quartile
	a_level_up: assert property (@(posedge clk) disable iff (!rst)
		(wr && !rd_issued && !clr) |=> (level >= $past(level)))
		else begin
			$error("level dropped on a write without read");
			fail_cnt++;
		end

endmodule

`default_nettype wire

//--- verif/srl_fifo_tb.sv
`timescale 1ns/1ps
`default_nettype none

module srl_fifo_tb
	import fifo_pkg::*;
();

	localparam int DATA_W    = DATA_W_DEF;
	localparam int RAM_DEPTH = 1 << ADDR_W_DEF;
	// ram plus input and output registers
	localparam int CAPACITY  = RAM_DEPTH + 2;
	localparam int TIMEOUT   = 2000;
	// one cycle beyond the 3 cycle fill latency
	localparam int SETTLE    = 4;

	logic              clk;
	logic              rst;
	logic              clr;
	logic              enq;
	logic              deq;
	logic [DATA_W-1:0] d_in;
	logic [DATA_W-1:0] d_out;
	logic              empty_n;
	logic              full_n;
	logic [1:0]        level;
	logic              have_n;
	logic              almost_full;

	// reference queue and running totals
	logic [DATA_W-1:0] model_q [$];
	int accepted     = 0;
	int delivered    = 0;
	int test_errors  = 0;
	int errors       = 0;
	int tests_run    = 0;
	int tests_failed = 0;
	int asrt_seen    = 0;
	bit timed_out    = 1'b0;

	tb_clk_gen clk_gen_i (
		.clk (clk),
		.rst (rst)
	);

	srl_fifo_top dut_i (
		.clk         (clk),
		.rst         (rst),
		.clr         (clr),
		.enq         (enq),
		.d_in        (d_in),
		.deq         (deq),
		.d_out       (d_out),
		.empty_n     (empty_n),
		.full_n      (full_n),
		.level       (level),
		.have_n      (have_n),
		.almost_full (almost_full)
	);

	bind srl_fifo_top srl_fifo_assertions asrt_i (
		.clk         (clk),
		.rst         (rst),
		.clr         (clr),
		.deq         (deq),
		.d_out       (d_out),
		.empty_n     (empty_n),
		.full_n      (full_n),
		.level       (level),
		.have_n      (have_n),
		.almost_full (almost_full),
		.push        (push),
		.take        (take),
		.rd_issued   (rd_issued)
	);

	////////////////////////////////////////
	// checking helpers
	////////////////////////////////////////

	task automatic compare_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		assert (act === exp)
			else begin
				$display("error at %0t: %s expected %h actual %h", $time, name, exp, act);
				test_errors++;
			end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout at %0t while %s", $time, what);
		test_errors++;
		timed_out = 1'b1;
	endtask

	// one line per test, bound failures included
	task automatic finish_test(input string name);
		test_errors += dut_i.asrt_i.fail_cnt - asrt_seen;
		asrt_seen = dut_i.asrt_i.fail_cnt;
		tests_run++;
		if (test_errors != 0) begin
			tests_failed++;
		end
		errors += test_errors;
		$display("test %s: %s, %0d errors", name, (test_errors == 0) ? "pass" : "fail",
			test_errors);
		test_errors = 0;
	endtask

	// edges happen at posedge, so the negedge view is what the DUT will see
	always @(negedge clk) begin
		if (!rst || clr) begin
			model_q.delete();
		end else begin
			if (deq && empty_n) begin
				if (model_q.size() == 0) begin
					$display("error at %0t: extra word %h on d_out", $time, d_out);
					test_errors++;
				end else begin
					compare_value("d_out", model_q.pop_front(), d_out);
				end
				delivered++;
			end
			if (enq && full_n) begin
				model_q.push_back(d_in);
				accepted++;
			end
		end
	end

	task automatic check_idle();
		compare_value("empty_n", 32'd0, 32'(empty_n));
		compare_value("full_n", 32'd1, 32'(full_n));
		compare_value("level", 32'd0, 32'(level));
		compare_value("have_n", 32'd0, 32'(have_n));
		compare_value("almost_full", 32'd0, 32'(almost_full));
	endtask

	// k words held with deq low, one of them sits in the output register
	task automatic check_status(input int k);
		int ram_words;
		int quart;
		ram_words = (k > RAM_DEPTH) ? RAM_DEPTH : k - 1;
		quart = ram_words / (RAM_DEPTH / 4);
		if (quart > 3) begin
			quart = 3;
		end
		compare_value("have_n", 32'(ram_words >= ALMOST_N_DEF), 32'(have_n));
		compare_value("almost_full", 32'(ram_words >= RAM_DEPTH - ALMOST_N_DEF),
			32'(almost_full));
		compare_value("level", quart, 32'(level));
		compare_value("full_n", 32'(k < CAPACITY), 32'(full_n));
		compare_value("empty_n", 32'd1, 32'(empty_n));
	endtask

	////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////

	task automatic random_traffic(input int cycles, input int deq_pct);
		repeat (cycles) begin
			@(posedge clk);
			enq  <= ($urandom % 32'd100) < 32'd70;
			deq  <= ($urandom % 32'd100) < 32'(deq_pct);
			d_in <= $urandom;
		end
	endtask

	task automatic drain_fifo();
		int n = 0;
		@(posedge clk);
		enq <= 1'b0;
		deq <= 1'b1;
		while (model_q.size() != 0 && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (model_q.size() != 0) begin
			report_timeout("draining the FIFO");
		end
		@(posedge clk);
		deq <= 1'b0;
		// nothing left should show up
		repeat (SETTLE + 2) @(negedge clk);
		compare_value("empty_n", 32'd0, 32'(empty_n));
	endtask

	////////////////////////////////////////
	// tests
	////////////////////////////////////////

	task automatic reset_test();
		int n = 0;
		while (rst !== 1'b1 && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (rst !== 1'b1) begin
			report_timeout("waiting for reset release");
		end
		@(negedge clk);
		check_idle();
		finish_test("reset");
	endtask

	task automatic order_test();
		int a0;
		int d0;
		a0 = accepted;
		d0 = delivered;
		// mostly filling, then mostly draining
		random_traffic(300, 30);
		random_traffic(300, 80);
		drain_fifo();
		compare_value("words out", 32'(accepted - a0), 32'(delivered - d0));
		finish_test("order");
	endtask

	task automatic capacity_test();
		int a0;
		int d0;
		int low_run = 0;
		int n = 0;
		a0 = accepted;
		d0 = delivered;
		@(posedge clk);
		enq <= 1'b1;
		deq <= 1'b0;
		// full once full_n has stayed low for a while
		while (low_run < 8 && n < TIMEOUT) begin
			@(posedge clk);
			d_in <= $urandom;
			@(negedge clk);
			low_run = full_n ? 0 : low_run + 1;
			n++;
		end
		if (low_run < 8) begin
			report_timeout("filling the FIFO");
		end
		compare_value("words in", CAPACITY, 32'(accepted - a0));
		drain_fifo();
		compare_value("words out", CAPACITY, 32'(delivered - d0));
		finish_test("capacity");
	endtask

	task automatic status_test();
		int a0;
		int n;
		a0 = accepted;
		for (int k = 1; k <= CAPACITY && !timed_out; k++) begin
			@(posedge clk);
			enq  <= 1'b1;
			deq  <= 1'b0;
			d_in <= $urandom;
			n = 0;
			do begin
				@(negedge clk);
				n++;
			end while (!full_n && n < TIMEOUT);
			if (!full_n) begin
				report_timeout("offering a word");
			end
			@(posedge clk);
			enq <= 1'b0;
			repeat (SETTLE) @(negedge clk);
			check_status(accepted - a0);
		end
		drain_fifo();
		check_idle();
		finish_test("status");
	endtask

	task automatic clear_test();
		int a0;
		int d0;
		int n = 0;
		int sent = 0;
		random_traffic(40, 25);
		@(posedge clk);
		clr <= 1'b1;
		@(posedge clk);
		clr <= 1'b0;
		enq <= 1'b0;
		deq <= 1'b0;
		@(negedge clk);
		check_idle();
		a0 = accepted;
		d0 = delivered;
		// fresh words after the clear
		// a word offered with full_n high goes in on the next edge
		while (sent < 10 && n < TIMEOUT) begin
			@(posedge clk);
			enq  <= 1'b1;
			deq  <= ($urandom % 32'd2) != 32'd0;
			d_in <= $urandom;
			@(negedge clk);
			if (full_n) begin
				sent++;
			end
			n++;
		end
		if (sent < 10) begin
			report_timeout("sending words after clear");
		end
		drain_fifo();
		compare_value("words in", 32'd10, 32'(accepted - a0));
		compare_value("words out", 32'd10, 32'(delivered - d0));
		finish_test("clear");
	endtask

	initial begin
		clr  = 1'b0;
		enq  = 1'b0;
		deq  = 1'b0;
		d_in = '0;
		void'($urandom(32'h4176_beb6));
		reset_test();
		if (!timed_out) begin
			order_test();
		end
		if (!timed_out) begin
			capacity_test();
		end
		if (!timed_out) begin
			status_test();
		end
		if (!timed_out) begin
			clear_test();
		end
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0 && !timed_out) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
src/fifo_pkg.sv
src/fifo_ram_if.sv
src/fifo_ram.sv
src/fifo_in_stage.sv
src/fifo_ctrl.sv
src/fifo_out_stage.sv
src/srl_fifo_top.sv
verif/tb_clk_gen.sv
verif/srl_fifo_assertions.sv
verif/srl_fifo_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
RUNFLAGS  = +verilator+error+limit+1000
TOP       = srl_fifo_tb
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUNFLAGS) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
